// File: rtl/wb_xbar_cfg_pkg.sv
// -------------------------------------------------------------------------
// Wishbone switch configuration with bus widths, FIFO depth and the
// address windows of the two slaves
// -------------------------------------------------------------------------
`default_nettype none

package wb_xbar_cfg_pkg;

  // Bus widths
  localparam int AW = 16;
  localparam int DW = 32;
  localparam int SW = DW / 8;

  // Queue depth is 2**FIFO_AW entries
  localparam int FIFO_AW = 2;

  // Two spare bits keep the modulo tag compare unambiguous
  localparam int TAG_W = FIFO_AW + 2;

  // Slave 0 covers 0x0000-0x0FFF, slave 1 covers 0x1000-0x1FFF
  localparam logic [AW-1:0] S0_BASE = 16'h0000;
  localparam logic [AW-1:0] S0_MASK = 16'hF000;
  localparam logic [AW-1:0] S1_BASE = 16'h1000;
  localparam logic [AW-1:0] S1_MASK = 16'hF000;

endpackage

`default_nettype wire

// File: rtl/wb_xbar_req_pkg.sv
// -------------------------------------------------------------------------
// Request and reply types shared by the ports of the Wishbone switch
// -------------------------------------------------------------------------
`default_nettype none

package wb_xbar_req_pkg;

  import wb_xbar_cfg_pkg::*;

  typedef logic [AW-1:0]    addr_t;
  typedef logic [DW-1:0]    data_t;
  typedef logic [SW-1:0]    sel_t;
  typedef logic [TAG_W-1:0] tag_t;

  // Request header as queued towards a slave
  typedef struct packed {
    addr_t addr;
    sel_t  sel;
    logic  we;
    tag_t  tag;
  } req_hdr_t;

  // Destination of a decoded beat
  typedef enum logic [1:0] {
    ROUTE_S0,
    ROUTE_S1,
    ROUTE_NONE
  } route_t;

  // Reply word, err set for unmapped addresses
  typedef struct packed {
    data_t data;
    logic  err;
  } rsp_t;

endpackage

`default_nettype wire

// File: rtl/xbar_link_if.sv
// -------------------------------------------------------------------------
// Read side of one queue between a master port and a slave port
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface xbar_link_if #(
  parameter type payload_t = wb_xbar_req_pkg::data_t
);

  import wb_xbar_req_pkg::*;

  // Head of the queue, valid while empty is low
  req_hdr_t hdr;
  payload_t wdata;
  logic     empty;
  // Pops the head on the clock edge
  logic     rden;

  // Side that owns the queue
  modport src (
    output hdr,
    output wdata,
    output empty,
    input  rden
  );

  // Side that drains the queue
  modport dst (
    input  hdr,
    input  wdata,
    input  empty,
    output rden
  );

endinterface

`default_nettype wire

// File: rtl/sync_fifo.sv
// -------------------------------------------------------------------------
// Single-clock FIFO, head word shown without read latency
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH  = 8,
  parameter int ADDR_W = 2
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] wr_data_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] rd_data_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [WIDTH-1:0] mem [2**ADDR_W];
  // Extra top bit tells full from empty
  logic [ADDR_W:0]  wr_ptr;
  logic [ADDR_W:0]  rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en_i && !full_o;
  assign do_rd = rd_en_i && !empty_o;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign rd_data_o = mem[rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr[ADDR_W-1:0]] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/wb_xbar_master_port.sv
// -------------------------------------------------------------------------
// Master side of the switch, decodes and tags beats, queues them per slave
// and returns replies in issue order
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_xbar_master_port (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  wb_xbar_req_pkg::addr_t wb_addr_i,
  input  wb_xbar_req_pkg::data_t wb_dat_i,
  input  wb_xbar_req_pkg::sel_t  wb_sel_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  output wb_xbar_req_pkg::data_t wb_dat_o,
  output logic                   wb_stall_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  input  wb_xbar_req_pkg::tag_t  tag_i,
  xbar_link_if.src               to_s0,
  xbar_link_if.src               to_s1,
  xbar_link_if.dst               from_s0,
  xbar_link_if.dst               from_s1
);

  import wb_xbar_cfg_pkg::*;
  import wb_xbar_req_pkg::*;

  route_t     route;
  req_hdr_t   hdr;
  logic       accept;
  logic       tgt_full;
  logic       s0_full;
  logic       s1_full;
  logic       ord_full;
  logic       ord_empty;
  logic [1:0] ord_q;
  route_t     ord_head;
  rsp_t       rsp;
  logic       rsp_vld;

  // -----------------------------------------------------------------------
  // Request path
  // -----------------------------------------------------------------------
  always_comb begin
    if ((wb_addr_i & S0_MASK) == S0_BASE) begin
      route = ROUTE_S0;
    end else if ((wb_addr_i & S1_MASK) == S1_BASE) begin
      route = ROUTE_S1;
    end else begin
      route = ROUTE_NONE;
    end
  end

  // Unmapped beats only need room in the order queue
  always_comb begin
    case (route)
      ROUTE_S0: tgt_full = s0_full;
      ROUTE_S1: tgt_full = s1_full;
      default:  tgt_full = 1'b0;
    endcase
  end

  assign wb_stall_o = tgt_full || ord_full;
  assign accept     = wb_cyc_i && wb_stb_i && !wb_stall_o;

  assign hdr = '{addr: wb_addr_i, sel: wb_sel_i, we: wb_we_i, tag: tag_i};

  sync_fifo #(.WIDTH($bits(req_hdr_t) + DW), .ADDR_W(FIFO_AW)) u_s0_req_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (accept && (route == ROUTE_S0)),
    .wr_data_i ({hdr, wb_dat_i}),
    .rd_en_i   (to_s0.rden),
    .rd_data_o ({to_s0.hdr, to_s0.wdata}),
    .full_o    (s0_full),
    .empty_o   (to_s0.empty)
  );

  sync_fifo #(.WIDTH($bits(req_hdr_t) + DW), .ADDR_W(FIFO_AW)) u_s1_req_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (accept && (route == ROUTE_S1)),
    .wr_data_i ({hdr, wb_dat_i}),
    .rd_en_i   (to_s1.rden),
    .rd_data_o ({to_s1.hdr, to_s1.wdata}),
    .full_o    (s1_full),
    .empty_o   (to_s1.empty)
  );

  // -----------------------------------------------------------------------
  // Reply path, one route entry per accepted beat
  // -----------------------------------------------------------------------
  sync_fifo #(.WIDTH($bits(route_t)), .ADDR_W(FIFO_AW)) u_ord_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (accept),
    .wr_data_i (route),
    .rd_en_i   (rsp_vld),
    .rd_data_o (ord_q),
    .full_o    (ord_full),
    .empty_o   (ord_empty)
  );

  assign ord_head = route_t'(ord_q);

  // Oldest entry retires once its reply is at the link head
  always_comb begin
    from_s0.rden = 1'b0;
    from_s1.rden = 1'b0;
    rsp          = '0;
    rsp_vld      = 1'b0;
    if (!ord_empty) begin
      case (ord_head)
        ROUTE_S0: begin
          rsp          = from_s0.wdata;
          rsp_vld      = !from_s0.empty;
          from_s0.rden = !from_s0.empty;
        end
        ROUTE_S1: begin
          rsp          = from_s1.wdata;
          rsp_vld      = !from_s1.empty;
          from_s1.rden = !from_s1.empty;
        end
        default: begin
          rsp.err = 1'b1;
          rsp_vld = 1'b1;
        end
      endcase
    end
  end

  assign wb_dat_o = rsp.data;
  assign wb_ack_o = rsp_vld && !rsp.err;
  assign wb_err_o = rsp_vld && rsp.err;

endmodule

`default_nettype wire

// File: rtl/wb_xbar_slave_port.sv
// -------------------------------------------------------------------------
// Slave side of the switch, serves the oldest queued request on the slave
// bus and queues its reply for the requesting master
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_xbar_slave_port (
  input  logic                   clk_i,
  input  logic                   rst_i,
  xbar_link_if.dst               from_m0,
  xbar_link_if.dst               from_m1,
  xbar_link_if.src               to_m0,
  xbar_link_if.src               to_m1,
  output wb_xbar_req_pkg::addr_t wb_addr_o,
  output wb_xbar_req_pkg::data_t wb_dat_o,
  output wb_xbar_req_pkg::sel_t  wb_sel_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  input  wb_xbar_req_pkg::data_t wb_dat_i,
  input  logic                   wb_stall_i,
  input  logic                   wb_ack_i
);

  import wb_xbar_cfg_pkg::*;
  import wb_xbar_req_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_ACK,
    RESPOND
  } state_t;

  state_t   state;
  logic     pick_m1;
  tag_t     tag_diff;
  // Served master, 1 for m1
  logic     cur_m;
  req_hdr_t cur_hdr;
  data_t    cur_wdata;
  rsp_t     rsp_q;
  logic     rsp_push;
  logic     rsp_full;
  logic     m0_full;
  logic     m1_full;

  // -----------------------------------------------------------------------
  // Oldest-first pick, the sign of the modulo tag difference gives the age
  // -----------------------------------------------------------------------
  assign tag_diff = from_m1.hdr.tag - from_m0.hdr.tag;
  assign pick_m1  = !from_m1.empty && (from_m0.empty || tag_diff[TAG_W-1]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (!from_m0.empty || !from_m1.empty) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          if (!wb_stall_i) begin
            state <= WAIT_ACK;
          end
        end
        WAIT_ACK: begin
          if (wb_ack_i) begin
            state <= RESPOND;
          end
        end
        RESPOND: begin
          if (!rsp_full) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request stays queued until its reply is pushed
  always_ff @(posedge clk_i) begin
    if (state == IDLE) begin
      cur_m     <= pick_m1;
      cur_hdr   <= pick_m1 ? from_m1.hdr : from_m0.hdr;
      cur_wdata <= pick_m1 ? from_m1.wdata : from_m0.wdata;
    end
    if ((state == WAIT_ACK) && wb_ack_i) begin
      rsp_q.data <= cur_hdr.we ? '0 : wb_dat_i;
      rsp_q.err  <= 1'b0;
    end
  end

  // Slave bus, one beat in flight
  assign wb_cyc_o  = (state == ISSUE) || (state == WAIT_ACK);
  assign wb_stb_o  = (state == ISSUE);
  assign wb_addr_o = cur_hdr.addr;
  assign wb_sel_o  = cur_hdr.sel;
  assign wb_we_o   = cur_hdr.we;
  assign wb_dat_o  = cur_wdata;

  // -----------------------------------------------------------------------
  // Reply queues, one per master
  // -----------------------------------------------------------------------
  assign rsp_full = cur_m ? m1_full : m0_full;
  assign rsp_push = (state == RESPOND) && !rsp_full;

  assign from_m0.rden = rsp_push && !cur_m;
  assign from_m1.rden = rsp_push && cur_m;

  // Header field unused on reply links
  assign to_m0.hdr = '0;
  assign to_m1.hdr = '0;

  sync_fifo #(.WIDTH($bits(rsp_t)), .ADDR_W(FIFO_AW)) u_m0_rsp_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (rsp_push && !cur_m),
    .wr_data_i (rsp_q),
    .rd_en_i   (to_m0.rden),
    .rd_data_o (to_m0.wdata),
    .full_o    (m0_full),
    .empty_o   (to_m0.empty)
  );

  sync_fifo #(.WIDTH($bits(rsp_t)), .ADDR_W(FIFO_AW)) u_m1_rsp_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (rsp_push && cur_m),
    .wr_data_i (rsp_q),
    .rd_en_i   (to_m1.rden),
    .rd_data_o (to_m1.wdata),
    .full_o    (m1_full),
    .empty_o   (to_m1.empty)
  );

endmodule

`default_nettype wire

// File: rtl/wb_xbar_top.sv
// -------------------------------------------------------------------------
// Two-master, two-slave pipelined Wishbone switch with in-order replies
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_xbar_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Master 0
  input  wb_xbar_req_pkg::addr_t m0_wb_addr_i,
  input  wb_xbar_req_pkg::data_t m0_wb_dat_i,
  input  wb_xbar_req_pkg::sel_t  m0_wb_sel_i,
  input  logic                   m0_wb_cyc_i,
  input  logic                   m0_wb_stb_i,
  input  logic                   m0_wb_we_i,
  output wb_xbar_req_pkg::data_t m0_wb_dat_o,
  output logic                   m0_wb_stall_o,
  output logic                   m0_wb_ack_o,
  output logic                   m0_wb_err_o,
  // Master 1
  input  wb_xbar_req_pkg::addr_t m1_wb_addr_i,
  input  wb_xbar_req_pkg::data_t m1_wb_dat_i,
  input  wb_xbar_req_pkg::sel_t  m1_wb_sel_i,
  input  logic                   m1_wb_cyc_i,
  input  logic                   m1_wb_stb_i,
  input  logic                   m1_wb_we_i,
  output wb_xbar_req_pkg::data_t m1_wb_dat_o,
  output logic                   m1_wb_stall_o,
  output logic                   m1_wb_ack_o,
  output logic                   m1_wb_err_o,
  // Slave 0
  output wb_xbar_req_pkg::addr_t s0_wb_addr_o,
  output wb_xbar_req_pkg::data_t s0_wb_dat_o,
  output wb_xbar_req_pkg::sel_t  s0_wb_sel_o,
  output logic                   s0_wb_cyc_o,
  output logic                   s0_wb_stb_o,
  output logic                   s0_wb_we_o,
  input  wb_xbar_req_pkg::data_t s0_wb_dat_i,
  input  logic                   s0_wb_stall_i,
  input  logic                   s0_wb_ack_i,
  // Slave 1
  output wb_xbar_req_pkg::addr_t s1_wb_addr_o,
  output wb_xbar_req_pkg::data_t s1_wb_dat_o,
  output wb_xbar_req_pkg::sel_t  s1_wb_sel_o,
  output logic                   s1_wb_cyc_o,
  output logic                   s1_wb_stb_o,
  output logic                   s1_wb_we_o,
  input  wb_xbar_req_pkg::data_t s1_wb_dat_i,
  input  logic                   s1_wb_stall_i,
  input  logic                   s1_wb_ack_i
);

  import wb_xbar_req_pkg::*;

  tag_t time_tag;

  // Request links
  xbar_link_if m0_to_s0 ();
  xbar_link_if m0_to_s1 ();
  xbar_link_if m1_to_s0 ();
  xbar_link_if m1_to_s1 ();

  // Reply links carry data with err
  xbar_link_if #(.payload_t(rsp_t)) s0_to_m0 ();
  xbar_link_if #(.payload_t(rsp_t)) s0_to_m1 ();
  xbar_link_if #(.payload_t(rsp_t)) s1_to_m0 ();
  xbar_link_if #(.payload_t(rsp_t)) s1_to_m1 ();

  // Global age stamp, one step per accepted beat on either master
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      time_tag <= '0;
    end else if ((m0_wb_cyc_i && m0_wb_stb_i && !m0_wb_stall_o) ||
                 (m1_wb_cyc_i && m1_wb_stb_i && !m1_wb_stall_o)) begin
      time_tag <= time_tag + 1'b1;
    end
  end

  wb_xbar_master_port u_m0_port (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_addr_i  (m0_wb_addr_i),
    .wb_dat_i   (m0_wb_dat_i),
    .wb_sel_i   (m0_wb_sel_i),
    .wb_cyc_i   (m0_wb_cyc_i),
    .wb_stb_i   (m0_wb_stb_i),
    .wb_we_i    (m0_wb_we_i),
    .wb_dat_o   (m0_wb_dat_o),
    .wb_stall_o (m0_wb_stall_o),
    .wb_ack_o   (m0_wb_ack_o),
    .wb_err_o   (m0_wb_err_o),
    .tag_i      (time_tag),
    .to_s0      (m0_to_s0),
    .to_s1      (m0_to_s1),
    .from_s0    (s0_to_m0),
    .from_s1    (s1_to_m0)
  );

  wb_xbar_master_port u_m1_port (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_addr_i  (m1_wb_addr_i),
    .wb_dat_i   (m1_wb_dat_i),
    .wb_sel_i   (m1_wb_sel_i),
    .wb_cyc_i   (m1_wb_cyc_i),
    .wb_stb_i   (m1_wb_stb_i),
    .wb_we_i    (m1_wb_we_i),
    .wb_dat_o   (m1_wb_dat_o),
    .wb_stall_o (m1_wb_stall_o),
    .wb_ack_o   (m1_wb_ack_o),
    .wb_err_o   (m1_wb_err_o),
    .tag_i      (time_tag),
    .to_s0      (m1_to_s0),
    .to_s1      (m1_to_s1),
    .from_s0    (s0_to_m1),
    .from_s1    (s1_to_m1)
  );

  wb_xbar_slave_port u_s0_port (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .from_m0    (m0_to_s0),
    .from_m1    (m1_to_s0),
    .to_m0      (s0_to_m0),
    .to_m1      (s0_to_m1),
    .wb_addr_o  (s0_wb_addr_o),
    .wb_dat_o   (s0_wb_dat_o),
    .wb_sel_o   (s0_wb_sel_o),
    .wb_cyc_o   (s0_wb_cyc_o),
    .wb_stb_o   (s0_wb_stb_o),
    .wb_we_o    (s0_wb_we_o),
    .wb_dat_i   (s0_wb_dat_i),
    .wb_stall_i (s0_wb_stall_i),
    .wb_ack_i   (s0_wb_ack_i)
  );

  wb_xbar_slave_port u_s1_port (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .from_m0    (m0_to_s1),
    .from_m1    (m1_to_s1),
    .to_m0      (s1_to_m0),
    .to_m1      (s1_to_m1),
    .wb_addr_o  (s1_wb_addr_o),
    .wb_dat_o   (s1_wb_dat_o),
    .wb_sel_o   (s1_wb_sel_o),
    .wb_cyc_o   (s1_wb_cyc_o),
    .wb_stb_o   (s1_wb_stb_o),
    .wb_we_o    (s1_wb_we_o),
    .wb_dat_i   (s1_wb_dat_i),
    .wb_stall_i (s1_wb_stall_i),
    .wb_ack_i   (s1_wb_ack_i)
  );

endmodule

`default_nettype wire

// File: verif/wb_xbar_checker.sv
// -------------------------------------------------------------------------
// Reply checker for the Wishbone switch, compares master replies in issue
// order and watches the idle and address-window rules
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wb_xbar_checker (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   idle_i,
  input  logic [1:0]             m_stall_i,
  input  logic [1:0]             m_ack_i,
  input  logic [1:0]             m_err_i,
  input  wb_xbar_req_pkg::data_t m0_dat_i,
  input  wb_xbar_req_pkg::data_t m1_dat_i,
  input  logic [1:0]             s_cyc_i,
  input  logic [1:0]             s_stb_i,
  input  wb_xbar_req_pkg::addr_t s0_addr_i,
  input  wb_xbar_req_pkg::addr_t s1_addr_i
);

  import wb_xbar_cfg_pkg::*;
  import wb_xbar_req_pkg::*;

  // Expected reply as {we, err, data}
  logic [DW+1:0] m0_exp_q [$];
  logic [DW+1:0] m1_exp_q [$];
  int            mismatch_cnt = 0;
  int            missing_cnt  = 0;
  int            extra_cnt    = 0;

  task automatic expect_reply(input int m, input logic we, input logic err, input data_t data);
    if (m == 0) begin
      m0_exp_q.push_back({we, err, data});
    end else begin
      m1_exp_q.push_back({we, err, data});
    end
  endtask

  function automatic int pending_count();
    return m0_exp_q.size() + m1_exp_q.size();
  endfunction

  function automatic int error_count();
    return mismatch_cnt + missing_cnt + extra_cnt;
  endfunction

  task automatic compare_reply(input int m, input logic ack, input logic err,
                               input data_t dat, input logic [DW+1:0] exp);
    logic  exp_we;
    logic  exp_err;
    data_t exp_dat;
    exp_we  = exp[DW+1];
    exp_err = exp[DW];
    exp_dat = exp[DW-1:0];
    if (ack !== !exp_err) begin
      mismatch_cnt++;
      $display("ERROR m%0d_wb_ack_o: got %h expected %h", m, ack, !exp_err);
    end else if (err !== exp_err) begin
      mismatch_cnt++;
      $display("ERROR m%0d_wb_err_o: got %h expected %h", m, err, exp_err);
    end else if (!exp_we && !exp_err && (dat !== exp_dat)) begin
      mismatch_cnt++;
      $display("ERROR m%0d_wb_dat_o: got %h expected %h", m, dat, exp_dat);
    end
  endtask

  task automatic check_low(input string name, input logic v);
    if (v !== 1'b0) begin
      mismatch_cnt++;
      $display("ERROR %s: got %h expected 0", name, v);
    end
  endtask

  task automatic report_extra(input int m);
    extra_cnt++;
    $display("Master %0d got a reply with no beat outstanding", m);
  endtask

  // -----------------------------------------------------------------------
  // Outputs are settled at the falling edge
  // -----------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (m_ack_i[0] || m_err_i[0]) begin
        if (m0_exp_q.size() == 0) begin
          report_extra(0);
        end else begin
          compare_reply(0, m_ack_i[0], m_err_i[0], m0_dat_i, m0_exp_q.pop_front());
        end
      end
      if (m_ack_i[1] || m_err_i[1]) begin
        if (m1_exp_q.size() == 0) begin
          report_extra(1);
        end else begin
          compare_reply(1, m_ack_i[1], m_err_i[1], m1_dat_i, m1_exp_q.pop_front());
        end
      end
      if (idle_i) begin
        check_low("m0_wb_stall_o", m_stall_i[0]);
        check_low("m1_wb_stall_o", m_stall_i[1]);
        check_low("m0_wb_ack_o", m_ack_i[0]);
        check_low("m1_wb_ack_o", m_ack_i[1]);
        check_low("m0_wb_err_o", m_err_i[0]);
        check_low("m1_wb_err_o", m_err_i[1]);
        check_low("s0_wb_cyc_o", s_cyc_i[0]);
        check_low("s1_wb_cyc_o", s_cyc_i[1]);
      end
      // Slave 0 owns 0x0xxx, slave 1 owns 0x1xxx
      if (s_cyc_i[0] && s_stb_i[0] && (s0_addr_i[15:12] != 4'h0)) begin
        mismatch_cnt++;
        $display("ERROR s0_wb_addr_o: got %h outside window 0000-0fff", s0_addr_i);
      end
      if (s_cyc_i[1] && s_stb_i[1] && (s1_addr_i[15:12] != 4'h1)) begin
        mismatch_cnt++;
        $display("ERROR s1_wb_addr_o: got %h outside window 1000-1fff", s1_addr_i);
      end
    end
  end

  task automatic close_out();
    missing_cnt = pending_count();
    if (missing_cnt != 0) begin
      $display("%0d issued beats never got a reply", missing_cnt);
    end
    $display("Errors: %0d mismatches, %0d missing replies, %0d extra replies",
             mismatch_cnt, missing_cnt, extra_cnt);
  endtask

endmodule

`default_nettype wire

// File: verif/tb_wb_xbar.sv
// -------------------------------------------------------------------------
// Testbench for the Wishbone switch with slave memory models, a stimulus
// table for both masters and a watchdog
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_wb_xbar;

  import wb_xbar_cfg_pkg::*;
  import wb_xbar_req_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 3;
  localparam int IDLE_CYCLES  = 6;
  localparam int NUM_ROWS     = 19;

  logic        clk_i;
  logic        rst_i;
  logic        idle_chk;
  logic [31:0] lfsr;

  // Master side indexed by master number
  logic [1:0][AW-1:0] m_addr;
  logic [1:0][DW-1:0] m_wdat;
  logic [1:0][SW-1:0] m_sel;
  logic [1:0]         m_cyc;
  logic [1:0]         m_stb;
  logic [1:0]         m_we;
  logic [1:0]         m_stall;
  logic [1:0]         m_ack;
  logic [1:0]         m_err;
  data_t              m0_rdat;
  data_t              m1_rdat;

  // Slave side indexed by slave number
  logic [1:0][AW-1:0] s_addr;
  logic [1:0][DW-1:0] s_wdat;
  logic [1:0][DW-1:0] s_rdat;
  logic [1:0][SW-1:0] s_sel;
  logic [1:0]         s_cyc;
  logic [1:0]         s_stb;
  logic [1:0]         s_we;
  logic [1:0]         s_stall;
  logic [1:0]         s_ack;

  // Stimulus table
  int    row_m    [NUM_ROWS];
  logic  row_we   [NUM_ROWS];
  addr_t row_addr [NUM_ROWS];
  data_t row_wdat [NUM_ROWS];
  data_t row_rdat [NUM_ROWS];
  logic  row_err  [NUM_ROWS];
  int    n_rows;

  wb_xbar_top u_dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .m0_wb_addr_i  (m_addr[0]),
    .m0_wb_dat_i   (m_wdat[0]),
    .m0_wb_sel_i   (m_sel[0]),
    .m0_wb_cyc_i   (m_cyc[0]),
    .m0_wb_stb_i   (m_stb[0]),
    .m0_wb_we_i    (m_we[0]),
    .m0_wb_dat_o   (m0_rdat),
    .m0_wb_stall_o (m_stall[0]),
    .m0_wb_ack_o   (m_ack[0]),
    .m0_wb_err_o   (m_err[0]),
    .m1_wb_addr_i  (m_addr[1]),
    .m1_wb_dat_i   (m_wdat[1]),
    .m1_wb_sel_i   (m_sel[1]),
    .m1_wb_cyc_i   (m_cyc[1]),
    .m1_wb_stb_i   (m_stb[1]),
    .m1_wb_we_i    (m_we[1]),
    .m1_wb_dat_o   (m1_rdat),
    .m1_wb_stall_o (m_stall[1]),
    .m1_wb_ack_o   (m_ack[1]),
    .m1_wb_err_o   (m_err[1]),
    .s0_wb_addr_o  (s_addr[0]),
    .s0_wb_dat_o   (s_wdat[0]),
    .s0_wb_sel_o   (s_sel[0]),
    .s0_wb_cyc_o   (s_cyc[0]),
    .s0_wb_stb_o   (s_stb[0]),
    .s0_wb_we_o    (s_we[0]),
    .s0_wb_dat_i   (s_rdat[0]),
    .s0_wb_stall_i (s_stall[0]),
    .s0_wb_ack_i   (s_ack[0]),
    .s1_wb_addr_o  (s_addr[1]),
    .s1_wb_dat_o   (s_wdat[1]),
    .s1_wb_sel_o   (s_sel[1]),
    .s1_wb_cyc_o   (s_cyc[1]),
    .s1_wb_stb_o   (s_stb[1]),
    .s1_wb_we_o    (s_we[1]),
    .s1_wb_dat_i   (s_rdat[1]),
    .s1_wb_stall_i (s_stall[1]),
    .s1_wb_ack_i   (s_ack[1])
  );

  wb_xbar_checker u_chk (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .idle_i    (idle_chk),
    .m_stall_i (m_stall),
    .m_ack_i   (m_ack),
    .m_err_i   (m_err),
    .m0_dat_i  (m0_rdat),
    .m1_dat_i  (m1_rdat),
    .s_cyc_i   (s_cyc),
    .s_stb_i   (s_stb),
    .s0_addr_i (s_addr[0]),
    .s1_addr_i (s_addr[1])
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // -------------------------------------------------------------------------
  // Slave memory models
  // -------------------------------------------------------------------------
  // One LFSR bit per slave and cycle
  always @(posedge clk_i) begin
    #DRIVE_DELAY;
    s_stall[0] = lfsr[31];
    lfsr       = lfsr_step(lfsr);
    s_stall[1] = lfsr[31];
    lfsr       = lfsr_step(lfsr);
  end

  for (genvar s = 0; s < 2; s++) begin : g_slave
    logic [DW-1:0] mem [1024];
    logic          take;
    logic          take_we;
    logic [9:0]    take_idx;
    logic [DW-1:0] take_dat;
    logic [SW-1:0] take_sel;

    // Fill word holds the slave number and the byte address
    initial begin
      take = 1'b0;
      for (int i = 0; i < 1024; i++) begin
        mem[i] = 32'h5A00_0000 + (s << 16) + (s << 12) + (i << 2);
      end
    end

    // Beat transfers on the coming rising edge
    always @(negedge clk_i) begin
      take     = s_cyc[s] && s_stb[s] && !s_stall[s];
      take_we  = s_we[s];
      take_idx = s_addr[s][11:2];
      take_dat = s_wdat[s];
      take_sel = s_sel[s];
    end

    // Ack one cycle after acceptance
    always @(posedge clk_i) begin
      #DRIVE_DELAY;
      s_ack[s] = take;
      if (take) begin
        if (take_we) begin
          for (int b = 0; b < SW; b++) begin
            if (take_sel[b]) begin
              mem[take_idx][8*b +: 8] = take_dat[8*b +: 8];
            end
          end
        end else begin
          s_rdat[s] = mem[take_idx];
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // Stimulus
  // -------------------------------------------------------------------------
  task automatic add_row(input int m, input logic we, input addr_t addr,
                         input data_t wdat, input data_t rdat, input logic err);
    row_m[n_rows]    = m;
    row_we[n_rows]   = we;
    row_addr[n_rows] = addr;
    row_wdat[n_rows] = wdat;
    row_rdat[n_rows] = rdat;
    row_err[n_rows]  = err;
    n_rows++;
  endtask

  task automatic load_table();
    n_rows = 0;
    // Slave 1 read queued behind a write and issued ahead of a slave 0 read
    add_row(0, 1'b1, 16'h1104, 32'h5555_5555, 32'h0, 1'b0);
    add_row(0, 1'b0, 16'h1100, 32'h0, 32'h5A01_1100, 1'b0);
    add_row(0, 1'b0, 16'h0044, 32'h0, 32'h5A00_0044, 1'b0);
    // Write then read back on slave 0
    add_row(0, 1'b1, 16'h0010, 32'hDEAD_BEEF, 32'h0, 1'b0);
    add_row(0, 1'b0, 16'h0010, 32'h0, 32'hDEAD_BEEF, 1'b0);
    // Unmapped beat followed by a mapped read
    add_row(0, 1'b0, 16'h3000, 32'h0, 32'h0, 1'b1);
    add_row(0, 1'b0, 16'h0010, 32'h0, 32'hDEAD_BEEF, 1'b0);
    add_row(0, 1'b1, 16'h0020, 32'h1111_1111, 32'h0, 1'b0);
    add_row(0, 1'b1, 16'h0024, 32'h2222_2222, 32'h0, 1'b0);
    add_row(0, 1'b0, 16'h0020, 32'h0, 32'h1111_1111, 1'b0);
    add_row(0, 1'b0, 16'h0024, 32'h0, 32'h2222_2222, 1'b0);
    // Master 1 in the slave 1 window
    add_row(1, 1'b1, 16'h1200, 32'hCAFE_F00D, 32'h0, 1'b0);
    add_row(1, 1'b0, 16'h1200, 32'h0, 32'hCAFE_F00D, 1'b0);
    add_row(1, 1'b0, 16'hF000, 32'h0, 32'h0, 1'b1);
    add_row(1, 1'b0, 16'h1204, 32'h0, 32'h5A01_1204, 1'b0);
    // Master 1 shares slave 0 with master 0
    add_row(1, 1'b1, 16'h0080, 32'h3333_3333, 32'h0, 1'b0);
    add_row(1, 1'b1, 16'h0084, 32'h4444_4444, 32'h0, 1'b0);
    add_row(1, 1'b0, 16'h0080, 32'h0, 32'h3333_3333, 1'b0);
    add_row(1, 1'b0, 16'h0084, 32'h0, 32'h4444_4444, 1'b0);
  endtask

  // Issues this master's rows back to back from a rising edge
  task automatic run_master(input int m);
    #DRIVE_DELAY;
    for (int r = 0; r < n_rows; r++) begin
      if (row_m[r] == m) begin
        m_cyc[m]  = 1'b1;
        m_stb[m]  = 1'b1;
        m_we[m]   = row_we[r];
        m_addr[m] = row_addr[r];
        m_wdat[m] = row_wdat[r];
        @(negedge clk_i);
        while (m_stall[m]) begin
          @(negedge clk_i);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        u_chk.expect_reply(m, row_we[r], row_err[r], row_rdat[r]);
      end
    end
    m_stb[m] = 1'b0;
  endtask

  initial begin
    rst_i    = 1'b1;
    idle_chk = 1'b0;
    lfsr     = 32'hfe081db0;
    m_addr   = '0;
    m_wdat   = '0;
    m_sel    = '1;
    m_cyc    = '0;
    m_stb    = '0;
    m_we     = '0;
    s_rdat   = '0;
    s_stall  = '0;
    s_ack    = '0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i    = 1'b0;
    idle_chk = 1'b1;
    repeat (IDLE_CYCLES) @(posedge clk_i);
    idle_chk = 1'b0;
    fork
      run_master(0);
      run_master(1);
    join
    while (u_chk.pending_count() != 0) begin
      @(posedge clk_i);
    end
    #DRIVE_DELAY;
    m_cyc = '0;
    // Window for stray replies
    repeat (8) @(posedge clk_i);
    u_chk.close_out();
    if (u_chk.error_count() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog allows 40 cycles per table row on top of reset and idle time
  initial begin
    repeat (NUM_ROWS * 40 + RESET_CYCLES + IDLE_CYCLES) @(posedge clk_i);
    $display("Timeout with %0d replies still outstanding", u_chk.pending_count());
    u_chk.close_out();
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/wb_xbar_cfg_pkg.sv
rtl/wb_xbar_req_pkg.sv
rtl/xbar_link_if.sv
rtl/sync_fifo.sv
rtl/wb_xbar_master_port.sv
rtl/wb_xbar_slave_port.sv
rtl/wb_xbar_top.sv
verif/wb_xbar_checker.sv
verif/tb_wb_xbar.sv
